//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tbExecCore
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

# The run passes only if the log holds the pass line.
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/execCore_assert.sv
// ================================================
// Wishbone handshake checks, bound into execCore.
// ================================================
`timescale 1ns/100ps

module execCore_assert (
    input logic clk,
    input logic arstN,
    input logic cyc,
    input logic stb,
    input logic ack
);

    ackInCycle: assert property (@(posedge clk) disable iff (!arstN) ack |-> (cyc && stb))
        else $error("ack high outside an active bus cycle");

    // Single-cycle acknowledge.
    ackOnePulse: assert property (@(posedge clk) disable iff (!arstN) ack |=> !ack)
        else $error("ack held high for two cycles");

    ackLowAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !ack)
        else $error("ack high in the first cycle after reset");

endmodule

bind execCore execCore_assert i_execCoreAssert (.clk, .arstN, .cyc, .stb, .ack);

//--- bench/tbExecCore.sv
// ================================================
// Table-driven testbench for the execute slice,
// acting as Wishbone master on the host port.
// ================================================
`timescale 1ns/100ps

module tbExecCore;

    typedef struct packed {
        logic        doWrite;
        logic [5:0]  wAdr;
        logic [31:0] wDat;
        logic        doRead;
        logic [5:0]  rAdr;
        logic [31:0] exp;
        logic [2:0]  test;
    } rowT;

    logic        clk;
    logic        arstN;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [5:0]  adr;
    logic [31:0] datW;
    logic [31:0] datR;
    logic        ack;

    rowT         rows [$];
    logic [2:0]  curTest;
    int          issued;
    int          xferCnt;
    int          limit;
    logic        tableReady = 1'b0;
    int          checks [8];
    int          errs [8];
    int          totalChecks;
    int          totalErrs;
    logic [31:0] got;
    logic        lastOfTest;

    execCore i_execCore (
        .clk, .arstN, .cyc, .stb, .we, .adr, .datW, .datR, .ack
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh, input logic [5:0] fn);
        mipsPkg::instrT w;
        w.rType.opcode = op;
        w.rType.rs     = rs;
        w.rType.rt     = rt;
        w.rType.rd     = rd;
        w.rType.shamt  = sh;
        w.rType.funct  = fn;
        return w;
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        mipsPkg::instrT w;
        w.iType.opcode = op;
        w.iType.rs     = rs;
        w.iType.rt     = rt;
        w.iType.imm    = imm;
        return w;
    endfunction

    task automatic addRow(input logic w, input logic [5:0] wAdr, input logic [31:0] wDat,
                          input logic r, input logic [5:0] rAdr, input logic [31:0] exp);
        rowT row;
        row.doWrite = w;
        row.wAdr    = wAdr;
        row.wDat    = wDat;
        row.doRead  = r;
        row.rAdr    = rAdr;
        row.exp     = exp;
        row.test    = curTest;
        rows.push_back(row);
        xferCnt = xferCnt + int'(w) + int'(r);
    endtask

    task automatic writeRead(input logic [5:0] a, input logic [31:0] d, input logic [31:0] e);
        addRow(1'b1, a, d, 1'b1, a, e);
    endtask

    task automatic issueRead(input logic [31:0] word, input logic [5:0] a,
                             input logic [31:0] e);
        issued = issued + 1;
        addRow(1'b1, mipsPkg::adrInstr, word, 1'b1, a, e);
    endtask

    // Status holds the wrapping issue count in 15:8 and the unsupported flag in bit 0.
    task automatic issueStatus(input logic [31:0] word, input logic unsup);
        issued = issued + 1;
        addRow(1'b1, mipsPkg::adrInstr, word, 1'b1, mipsPkg::adrStatus,
               {16'h0, 8'(issued), 7'h0, unsup});
    endtask

    task automatic readBack(input logic [5:0] a, input logic [31:0] e);
        addRow(1'b0, 6'h00, 32'h0, 1'b1, a, e);
    endtask

    task automatic buildTable();
        curTest = 3'd1;
        writeRead(1, 32'h0000_0007, 32'h0000_0007);
        writeRead(2, 32'h0000_0003, 32'h0000_0003);
        writeRead(3, 32'hFFFF_FFF0, 32'hFFFF_FFF0);
        writeRead(4, 32'h8000_0000, 32'h8000_0000);
        writeRead(5, 32'h0F0F_00FF, 32'h0F0F_00FF);
        writeRead(7, 32'h1234_5678, 32'h1234_5678);
        writeRead(31, 32'hA5A5_5A5A, 32'hA5A5_5A5A);
        writeRead(0, 32'hDEAD_BEEF, 32'h0000_0000); // Register 0 stays zero.
        curTest = 3'd2;
        issueRead(rWord(mipsPkg::opAlu, 1, 3, 10, 0, mipsPkg::fnAdd), 10, 32'hFFFF_FFF7);
        issueRead(rWord(mipsPkg::opAlu, 1, 2, 11, 0, mipsPkg::fnSub), 11, 32'h0000_0004);
        issueRead(rWord(mipsPkg::opAlu, 5, 7, 12, 0, mipsPkg::fnAnd), 12, 32'h0204_0078);
        issueRead(rWord(mipsPkg::opAlu, 5, 7, 13, 0, mipsPkg::fnOr), 13, 32'h1F3F_56FF);
        issueRead(rWord(mipsPkg::opAlu, 5, 7, 14, 0, mipsPkg::fnXor), 14, 32'h1D3B_5687);
        issueRead(rWord(mipsPkg::opAlu, 1, 2, 15, 0, mipsPkg::fnNor), 15, 32'hFFFF_FFF8);
        issueRead(rWord(mipsPkg::opAlu, 0, 7, 16, 4, mipsPkg::fnSll), 16, 32'h2345_6780);
        issueRead(rWord(mipsPkg::opAlu, 0, 3, 17, 2, mipsPkg::fnSra), 17, 32'hFFFF_FFFC);
        issueRead(rWord(mipsPkg::opAlu, 0, 4, 18, 4, mipsPkg::fnSrl), 18, 32'h0800_0000);
        issueRead(rWord(mipsPkg::opAlu, 1, 2, 19, 0, mipsPkg::fnSllv), 19, 32'h0000_0180);
        issueRead(rWord(mipsPkg::opAlu, 2, 3, 20, 0, mipsPkg::fnSrlv), 20, 32'h1FFF_FFFE);
        issueRead(rWord(mipsPkg::opAlu, 3, 1, 21, 0, mipsPkg::fnSlt), 21, 32'h0000_0001);
        issueRead(rWord(mipsPkg::opAlu, 3, 1, 22, 0, mipsPkg::fnSltu), 22, 32'h0000_0000);
        curTest = 3'd3;
        issueRead(iWord(mipsPkg::opAddi, 1, 8, 16'hFFF0), 8, 32'hFFFF_FFF7);
        issueRead(iWord(mipsPkg::opAddiu, 2, 9, 16'h8000), 9, 32'hFFFF_8003);
        issueRead(iWord(mipsPkg::opSlti, 1, 21, 16'hFFF8), 21, 32'h0000_0000);
        issueRead(iWord(mipsPkg::opSltiu, 3, 30, 16'hFFFF), 30, 32'h0000_0001);
        issueRead(iWord(mipsPkg::opAndi, 3, 14, 16'h8FF0), 14, 32'h0000_8FF0);
        issueRead(iWord(mipsPkg::opOri, 4, 15, 16'h8001), 15, 32'h8000_8001);
        issueRead(iWord(mipsPkg::opXori, 3, 16, 16'hFFFF), 16, 32'hFFFF_000F);
        issueRead(iWord(mipsPkg::opLui, 0, 17, 16'h8421), 17, 32'h8421_0000);
        curTest = 3'd4;
        issueRead(rWord(mipsPkg::opAlu, 1, 6, 10, 0, mipsPkg::fnMovn), 10, 32'hFFFF_FFF7);
        issueRead(rWord(mipsPkg::opAlu, 1, 2, 11, 0, mipsPkg::fnMovn), 11, 32'h0000_0007);
        issueRead(rWord(mipsPkg::opAlu, 7, 6, 12, 0, mipsPkg::fnMovz), 12, 32'h1234_5678);
        issueRead(rWord(mipsPkg::opAlu, 7, 2, 13, 0, mipsPkg::fnMovz), 13, 32'h1F3F_56FF);
        curTest = 3'd5;
        issueRead(rWord(mipsPkg::opAlu, 3, 1, 0, 0, mipsPkg::fnMult), mipsPkg::adrLo,
                  32'hFFFF_FF90);
        readBack(mipsPkg::adrHi, 32'hFFFF_FFFF);
        issueRead(rWord(mipsPkg::opAlu, 0, 0, 23, 0, mipsPkg::fnMfhi), 23, 32'hFFFF_FFFF);
        issueRead(rWord(mipsPkg::opAlu, 3, 1, 0, 0, mipsPkg::fnMultu), mipsPkg::adrHi,
                  32'h0000_0006);
        issueRead(rWord(mipsPkg::opAlu, 0, 0, 24, 0, mipsPkg::fnMflo), 24, 32'hFFFF_FF90);
        issueRead(rWord(mipsPkg::opSpecial2, 1, 2, 0, 0, mipsPkg::fnMadd), mipsPkg::adrLo,
                  32'hFFFF_FFA5);
        issueRead(rWord(mipsPkg::opSpecial2, 1, 1, 0, 0, mipsPkg::fnMsub), mipsPkg::adrLo,
                  32'hFFFF_FF74);
        readBack(mipsPkg::adrHi, 32'h0000_0006);
        issueRead(rWord(mipsPkg::opAlu, 7, 0, 0, 0, mipsPkg::fnMthi), mipsPkg::adrHi,
                  32'h1234_5678);
        issueRead(rWord(mipsPkg::opAlu, 5, 0, 0, 0, mipsPkg::fnMtlo), mipsPkg::adrLo,
                  32'h0F0F_00FF);
        issueRead(rWord(mipsPkg::opSpecial2, 1, 3, 25, 0, mipsPkg::fnMul), 25, 32'hFFFF_FF90);
        readBack(mipsPkg::adrLo, 32'h0F0F_00FF); // MUL keeps LO.
        issueRead(rWord(mipsPkg::opSpecial2, 18, 0, 26, 0, mipsPkg::fnClz), 26, 32'd4);
        issueRead(rWord(mipsPkg::opSpecial2, 3, 0, 27, 0, mipsPkg::fnClo), 27, 32'd28);
        curTest = 3'd6;
        issueStatus(iWord(mipsPkg::opBeq, 1, 2, 16'h0010), 1'b1);
        readBack(2, 32'h0000_0003);
        issueStatus(iWord(mipsPkg::opLw, 0, 1, 16'h0000), 1'b1);
        readBack(1, 32'h0000_0007);
        issueStatus(32'hFFFF_FFFF, 1'b1); // Unknown opcode 0x3F.
        readBack(31, 32'hA5A5_5A5A);
        issueStatus(rWord(mipsPkg::opAlu, 1, 2, 28, 0, mipsPkg::fnAdd), 1'b0);
        readBack(28, 32'h0000_000A);
    endtask

    // One classic cycle; the slave answers within a cycle.
    task automatic busXfer(input logic write, input logic [5:0] address,
                           input logic [31:0] data, output logic [31:0] readData);
        @(posedge clk);
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= write;
        adr  <= address;
        datW <= data;
        do
            @(negedge clk);
        while (!ack);
        readData = datR;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic compare(input logic [5:0] address, input logic [31:0] value,
                           input logic [31:0] exp, input logic [2:0] test);
        checks[test] = checks[test] + 1;
        assert (value === exp)
        else
        begin
            $display("FAIL test %0d datR at adr 0x%02h: got 0x%08h, expected 0x%08h",
                     test, address, value, exp);
            errs[test] = errs[test] + 1;
        end
    endtask

    initial
    begin
        cyc   <= 1'b0;
        stb   <= 1'b0;
        we    <= 1'b0;
        adr   <= 6'h00;
        datW  <= 32'h0;
        arstN <= 1'b0;
        issued  = 0;
        xferCnt = 36; // Reset scan below.
        buildTable();
        limit = xferCnt * 5 * 10 + 200;
        tableReady = 1'b1;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        for (int a = 0; a <= 35; a++)
        begin
            busXfer(1'b0, 6'(a), 32'h0, got);
            compare(6'(a), got, 32'h0, 3'd1);
        end
        foreach (rows[i])
        begin
            if (rows[i].doWrite)
                busXfer(1'b1, rows[i].wAdr, rows[i].wDat, got);
            if (rows[i].doRead)
            begin
                busXfer(1'b0, rows[i].rAdr, 32'h0, got);
                compare(rows[i].rAdr, got, rows[i].exp, rows[i].test);
            end
            lastOfTest = (i == rows.size() - 1);
            if (!lastOfTest)
                lastOfTest = (rows[i + 1].test != rows[i].test);
            if (lastOfTest)
                $display("test %0d: %0d checks, %0d errors", rows[i].test,
                         checks[rows[i].test], errs[rows[i].test]);
        end
        totalChecks = 0;
        totalErrs   = 0;
        for (int t = 0; t < 8; t++)
        begin
            totalChecks = totalChecks + checks[t];
            totalErrs   = totalErrs + errs[t];
        end
        $display("summary: %0d checks, %0d errors", totalChecks, totalErrs);
        if (totalErrs == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        wait (tableReady);
        #(limit);
        $display("Timeout: the slave stopped acknowledging after %0d ns", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- hdl/alu.sv
// ================================================
// Combinational integer ALU for the register group
// operations, conditional moves and HI/LO reads.
// ================================================
`timescale 1ns/100ps

module alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [31:0] hi,
    input  logic [31:0] lo,
    input  logic [4:0]  shamt,
    input  logic [5:0]  func,
    output logic [31:0] result,
    output logic        writeOk
);

    always_comb
    begin
        result  = '0;
        writeOk = 1'b1;
        case (func)
            mipsPkg::fnAdd, mipsPkg::fnAddu: result = a + b;
            mipsPkg::fnSub, mipsPkg::fnSubu: result = a - b;
            mipsPkg::fnSll:  result = b << shamt;
            mipsPkg::fnSllv: result = b << a[4:0];
            mipsPkg::fnSrl:  result = b >> shamt;
            mipsPkg::fnSrlv: result = b >> a[4:0];
            mipsPkg::fnSra:  result = $signed(b) >>> shamt;
            mipsPkg::fnSrav: result = $signed(b) >>> a[4:0];
            mipsPkg::fnAnd:  result = a & b;
            mipsPkg::fnOr:   result = a | b;
            mipsPkg::fnXor:  result = a ^ b;
            mipsPkg::fnNor:  result = ~(a | b);
            mipsPkg::fnSlt:  result = {31'b0, $signed(a) < $signed(b)};
            mipsPkg::fnSltu: result = {31'b0, a < b};
            mipsPkg::fnMovn:
            begin
                result  = a;
                writeOk = (b != '0); // Write suppressed when rt is zero.
            end
            mipsPkg::fnMovz:
            begin
                result  = a;
                writeOk = (b == '0);
            end
            mipsPkg::fnMfhi: result = hi;
            mipsPkg::fnMflo: result = lo;
            default: ;
        endcase
    end

endmodule

//--- hdl/decoder.sv
// ================================================
// Control decoder: opcode and funct to control flags
// and the ALU or multiply operation code.
// ================================================
`timescale 1ns/100ps

module decoder (
    input  logic [5:0] opCode,
    input  logic [5:0] funcCode,
    output logic [1:0] regDst,
    output logic       branch,
    output logic       jump,
    output logic       memRead,
    output logic       aluOp,
    output logic       mulOp,
    output logic       aluSrc,
    output logic       regWrite,
    output logic       shiftSel,
    output logic       unsgnSel,
    output logic [5:0] func
);

    always_comb
    begin
        regDst   = 2'b00;
        branch   = 1'b0;
        jump     = 1'b0;
        memRead  = 1'b0;
        aluOp    = 1'b0;
        mulOp    = 1'b0;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        shiftSel = 1'b0;
        unsgnSel = 1'b0;
        func     = 6'b000000;

        case (opCode)
            mipsPkg::opAlu:
                case (funcCode)
                    mipsPkg::fnAdd, mipsPkg::fnAddu, mipsPkg::fnSub, mipsPkg::fnSubu,
                    mipsPkg::fnSll, mipsPkg::fnSllv, mipsPkg::fnSra, mipsPkg::fnSrav,
                    mipsPkg::fnSrl, mipsPkg::fnSrlv, mipsPkg::fnAnd, mipsPkg::fnOr,
                    mipsPkg::fnXor, mipsPkg::fnNor, mipsPkg::fnSlt, mipsPkg::fnSltu,
                    mipsPkg::fnMovn, mipsPkg::fnMovz, mipsPkg::fnMfhi, mipsPkg::fnMflo:
                    begin
                        regDst   = 2'b01;
                        func     = funcCode;
                        aluOp    = 1'b1;
                        regWrite = 1'b1;
                    end
                    mipsPkg::fnMult, mipsPkg::fnMultu, mipsPkg::fnMthi, mipsPkg::fnMtlo:
                    begin
                        func  = funcCode; // HI/LO only, no register result.
                        aluOp = 1'b1;
                    end
                    mipsPkg::fnJr:   jump = 1'b1;
                    mipsPkg::fnJalr:
                    begin
                        regDst = 2'b01;
                        jump   = 1'b1;
                    end
                    default: ;
                endcase

            mipsPkg::opSpecial2:
                case (funcCode)
                    mipsPkg::fnMul, mipsPkg::fnClz, mipsPkg::fnClo:
                    begin
                        regDst   = 2'b01;
                        func     = funcCode;
                        mulOp    = 1'b1;
                        regWrite = 1'b1;
                    end
                    mipsPkg::fnMadd, mipsPkg::fnMaddu, mipsPkg::fnMsub, mipsPkg::fnMsubu:
                    begin
                        func  = funcCode;
                        mulOp = 1'b1;
                    end
                    default: ;
                endcase

            mipsPkg::opAddi, mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu,
            mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui:
            begin
                aluOp    = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                case (opCode)
                    mipsPkg::opAddi:  func = mipsPkg::fnAdd;
                    mipsPkg::opAddiu: func = mipsPkg::fnAddu;
                    mipsPkg::opSlti:  func = mipsPkg::fnSlt;
                    mipsPkg::opSltiu: func = mipsPkg::fnSltu;
                    mipsPkg::opLui:
                    begin
                        func     = mipsPkg::fnAdd; // rs is zero in a LUI word.
                        shiftSel = 1'b1;
                    end
                    default:
                    begin
                        unsgnSel = 1'b1; // Logical immediates zero-extend.
                        func     = (opCode == mipsPkg::opAndi) ? mipsPkg::fnAnd :
                                   (opCode == mipsPkg::opOri)  ? mipsPkg::fnOr  :
                                                                 mipsPkg::fnXor;
                    end
                endcase
            end

            mipsPkg::opBranch, mipsPkg::opBeq, mipsPkg::opBne,
            mipsPkg::opBlez, mipsPkg::opBgtz:
            begin
                branch = 1'b1;
                aluSrc = 1'b1;
            end

            mipsPkg::opJ: jump = 1'b1;
            mipsPkg::opJal:
            begin
                regDst = 2'b10; // Link register.
                jump   = 1'b1;
            end

            mipsPkg::opLb, mipsPkg::opLh, mipsPkg::opLw, mipsPkg::opLbu, mipsPkg::opLhu:
            begin
                memRead = 1'b1;
                aluSrc  = 1'b1;
            end

            mipsPkg::opSb, mipsPkg::opSh, mipsPkg::opSw: ; // Stores are not executed.
            default: ;
        endcase
    end

endmodule

//--- hdl/execCore.sv
// ================================================
// Execute slice top with its Wishbone classic slave.
// Writing adrInstr issues one instruction word.
// ================================================
`timescale 1ns/100ps

module execCore (
    input  logic        clk,
    input  logic        arstN,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [5:0]  adr,
    input  logic [31:0] datW,
    output logic [31:0] datR,
    output logic        ack
);

    mipsPkg::instrT instr;
    logic [1:0]  regDst;
    logic        branch, jump, memRead, aluOp, mulOp;
    logic        aluSrc, regWrite, shiftSel, unsgnSel;
    logic [5:0]  func;
    logic        xfer, issue, hostWr, unsupported, writeOk;
    logic [4:0]  rdAdrA, dest, wrAdr;
    logic        wrEn;
    logic [mipsPkg::dataW-1:0] rdDatA, rdDatB, immExt, aluB;
    logic [31:0] aluResult, mulResult, hi, lo, wbDat, wrDat;
    logic        unsupQ;
    logic [7:0]  issueCnt;

    assign xfer   = cyc & stb & ~ack;
    assign issue  = xfer & we & (adr == mipsPkg::adrInstr);
    assign hostWr = xfer & we & ~adr[5];
    assign instr  = datW; // Word decoded in the cycle it is written.

    decoder i_decoder (
        .opCode(instr.rType.opcode), .funcCode(instr.rType.funct),
        .regDst, .branch, .jump, .memRead, .aluOp, .mulOp,
        .aluSrc, .regWrite, .shiftSel, .unsgnSel, .func
    );

    // LUI takes priority over the sign choice.
    assign immExt = shiftSel ? {instr.iType.imm, 16'b0} :
                    unsgnSel ? {16'b0, instr.iType.imm} :
                               {{16{instr.iType.imm[15]}}, instr.iType.imm};
    assign aluB   = aluSrc ? immExt : rdDatB;

    alu i_alu (
        .a(rdDatA), .b(aluB), .hi, .lo, .shamt(instr.rType.shamt),
        .func, .result(aluResult), .writeOk
    );

    mulUnit i_mulUnit (
        .clk, .arstN, .issue, .aluOp, .mulOp, .func,
        .a(rdDatA), .b(rdDatB), .hi, .lo, .result(mulResult)
    );

    always_comb
    begin
        case (regDst)
            2'b01:   dest = instr.rType.rd;
            2'b10:   dest = 5'd31;
            default: dest = instr.rType.rt;
        endcase
    end

    // One write port shared by host writes and write-back.
    assign wbDat  = mulOp ? mulResult : aluResult;
    assign rdAdrA = issue ? instr.rType.rs : adr[4:0];
    assign wrEn   = hostWr | (issue & regWrite & writeOk);
    assign wrAdr  = issue ? dest : adr[4:0];
    assign wrDat  = issue ? wbDat : datW;

    regFile i_regFile (
        .clk, .arstN, .rdAdrA, .rdAdrB(instr.rType.rt), .wrAdr, .wrEn, .wrDat,
        .rdDatA, .rdDatB
    );

    assign unsupported = branch | jump | memRead | ~(aluOp | mulOp);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            ack      <= 1'b0;
            unsupQ   <= 1'b0;
            issueCnt <= '0;
        end
        else
        begin
            ack <= xfer;
            if (issue)
            begin
                unsupQ   <= unsupported;
                issueCnt <= issueCnt + 8'd1; // Wraps.
            end
        end
    end

    always_comb
    begin
        case (adr)
            mipsPkg::adrHi:     datR = hi;
            mipsPkg::adrLo:     datR = lo;
            mipsPkg::adrStatus: datR = {16'b0, issueCnt, 7'b0, unsupQ};
            default:            datR = adr[5] ? '0 : rdDatA;
        endcase
    end

endmodule

//--- hdl/mipsPkg.sv
// ================================================
// Shared encodings for the execute slice: opcodes,
// funct codes, host address map, instruction views.
// ================================================
package mipsPkg;

    localparam int dataW  = 32;
    localparam int regCnt = 32;

    // Primary opcodes.
    localparam logic [5:0] opAlu      = 6'h00;
    localparam logic [5:0] opBranch   = 6'h01;
    localparam logic [5:0] opJ        = 6'h02;
    localparam logic [5:0] opJal      = 6'h03;
    localparam logic [5:0] opBeq      = 6'h04;
    localparam logic [5:0] opBne      = 6'h05;
    localparam logic [5:0] opBlez     = 6'h06;
    localparam logic [5:0] opBgtz     = 6'h07;
    localparam logic [5:0] opAddi     = 6'h08;
    localparam logic [5:0] opAddiu    = 6'h09;
    localparam logic [5:0] opSlti     = 6'h0A;
    localparam logic [5:0] opSltiu    = 6'h0B;
    localparam logic [5:0] opAndi     = 6'h0C;
    localparam logic [5:0] opOri      = 6'h0D;
    localparam logic [5:0] opXori     = 6'h0E;
    localparam logic [5:0] opLui      = 6'h0F;
    localparam logic [5:0] opSpecial2 = 6'h1C;
    localparam logic [5:0] opLb       = 6'h20;
    localparam logic [5:0] opLh       = 6'h21;
    localparam logic [5:0] opLw       = 6'h23;
    localparam logic [5:0] opLbu      = 6'h24;
    localparam logic [5:0] opLhu      = 6'h25;
    localparam logic [5:0] opSb       = 6'h28;
    localparam logic [5:0] opSh       = 6'h29;
    localparam logic [5:0] opSw       = 6'h2B;

    // Register group funct codes, also the ALU operation codes.
    localparam logic [5:0] fnSll   = 6'h00;
    localparam logic [5:0] fnSrl   = 6'h02;
    localparam logic [5:0] fnSra   = 6'h03;
    localparam logic [5:0] fnSllv  = 6'h04;
    localparam logic [5:0] fnSrlv  = 6'h06;
    localparam logic [5:0] fnSrav  = 6'h07;
    localparam logic [5:0] fnJr    = 6'h08;
    localparam logic [5:0] fnJalr  = 6'h09;
    localparam logic [5:0] fnMovz  = 6'h0A;
    localparam logic [5:0] fnMovn  = 6'h0B;
    localparam logic [5:0] fnMfhi  = 6'h10;
    localparam logic [5:0] fnMthi  = 6'h11;
    localparam logic [5:0] fnMflo  = 6'h12;
    localparam logic [5:0] fnMtlo  = 6'h13;
    localparam logic [5:0] fnMult  = 6'h18;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnXor   = 6'h26;
    localparam logic [5:0] fnNor   = 6'h27;
    localparam logic [5:0] fnSlt   = 6'h2A;
    localparam logic [5:0] fnSltu  = 6'h2B;

    // Second register group, only valid together with mulOp.
    localparam logic [5:0] fnMadd  = 6'h00;
    localparam logic [5:0] fnMaddu = 6'h01;
    localparam logic [5:0] fnMul   = 6'h02;
    localparam logic [5:0] fnMsub  = 6'h04;
    localparam logic [5:0] fnMsubu = 6'h05;
    localparam logic [5:0] fnClz   = 6'h20;
    localparam logic [5:0] fnClo   = 6'h21;

    // Host word addresses; 0x00 to 0x1F are the registers.
    localparam logic [5:0] adrInstr  = 6'h20;
    localparam logic [5:0] adrHi     = 6'h21;
    localparam logic [5:0] adrLo     = 6'h22;
    localparam logic [5:0] adrStatus = 6'h23;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrT;

endpackage

//--- hdl/mulUnit.sv
// ================================================
// HI/LO accumulator with multiply, multiply-add and
// subtract, MUL and the leading-bit counters.
// ================================================
`timescale 1ns/100ps

module mulUnit (
    input  logic        clk,
    input  logic        arstN,
    input  logic        issue,
    input  logic        aluOp,
    input  logic        mulOp,
    input  logic [5:0]  func,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] hi,
    output logic [31:0] lo,
    output logic [31:0] result
);

    logic signed [63:0] prodS;
    logic        [63:0] prodU;
    logic        [63:0] acc;
    logic        [31:0] cntIn;
    logic        [5:0]  lead;

    assign prodS = 64'($signed(a)) * 64'($signed(b));
    assign prodU = 64'(a) * 64'(b);
    assign acc   = {hi, lo};

    // CLO counts leading zeros of the inverted word.
    always_comb
    begin
        cntIn = (func == mipsPkg::fnClo) ? ~a : a;
        lead  = 6'd32;
        for (int i = 0; i < 32; i++)
            if (cntIn[i])
                lead = 6'(31 - i);
    end

    always_comb
    begin
        case (func)
            mipsPkg::fnMul:                result = prodS[31:0];
            mipsPkg::fnClz, mipsPkg::fnClo: result = {26'b0, lead};
            default:                       result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hi <= '0;
            lo <= '0;
        end
        else if (issue && aluOp)
        begin
            case (func)
                mipsPkg::fnMult:  {hi, lo} <= prodS;
                mipsPkg::fnMultu: {hi, lo} <= prodU;
                mipsPkg::fnMthi:  hi <= a;
                mipsPkg::fnMtlo:  lo <= a;
                default: ;
            endcase
        end
        else if (issue && mulOp)
        begin
            case (func)
                mipsPkg::fnMadd:  {hi, lo} <= acc + prodS;
                mipsPkg::fnMaddu: {hi, lo} <= acc + prodU;
                mipsPkg::fnMsub:  {hi, lo} <= acc - prodS;
                mipsPkg::fnMsubu: {hi, lo} <= acc - prodU;
                default: ; // MUL, CLO and CLZ keep HI/LO.
            endcase
        end
    end

endmodule

//--- hdl/regFile.sv
// ================================================
// Register file with two asynchronous read ports.
// ================================================
`timescale 1ns/100ps

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rdAdrA,
    input  logic [4:0]  rdAdrB,
    input  logic [4:0]  wrAdr,
    input  logic        wrEn,
    input  logic [31:0] wrDat,
    output logic [31:0] rdDatA,
    output logic [31:0] rdDatB
);

    logic [mipsPkg::dataW-1:0] regs [mipsPkg::regCnt];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < mipsPkg::regCnt; i++)
                regs[i] <= '0;
        end
        else if (wrEn && wrAdr != 5'd0)
            regs[wrAdr] <= wrDat; // Register 0 is never written.
    end

    assign rdDatA = regs[rdAdrA];
    assign rdDatB = regs[rdAdrB];

endmodule

//--- tb.f
hdl/mipsPkg.sv
hdl/decoder.sv
hdl/alu.sv
hdl/mulUnit.sv
hdl/regFile.sv
hdl/execCore.sv
bench/execCore_assert.sv
bench/tbExecCore.sv
